// File: Bender.yml
package:
  name: kfmmc_interface

sources:
  - kfmmc_bus_pkg.sv
  - kfmmc_host_pkg.sv
  - kfmmc_request_decode.sv
  - kfmmc_clock_gen.sv
  - kfmmc_lane.sv
  - kfmmc_status.sv
  - kfmmc_interface.sv
  - target: test
    files:
      - kfmmc_properties.sv
      - tb_kfmmc_interface.sv

// File: compile.f
kfmmc_bus_pkg.sv
kfmmc_host_pkg.sv
kfmmc_request_decode.sv
kfmmc_clock_gen.sv
kfmmc_lane.sv
kfmmc_status.sv
kfmmc_interface.sv
kfmmc_properties.sv
tb_kfmmc_interface.sv

// File: kfmmc_bus_pkg.sv
// MMC card bus definitions
`default_nettype none

package kfmmc_bus_pkg;

    // One byte on a serial line, sent most significant bit first
    typedef logic [7:0] mmc_byte_t;

    typedef logic [6:0]  cmd_crc_t;
    typedef logic [15:0] dat_crc_t;

    // CRC-7, taps after bits 0 and 3
    localparam cmd_crc_t CMD_CRC_POLY = 7'h09;

    // CRC-16 CCITT
    localparam dat_crc_t DAT_CRC_POLY = 16'h1021;

    // Full card clock period in system cycles, upper seven bits are the half period
    typedef logic [7:0] divisor_t;

    // Sampled card lines
    typedef struct packed {
        logic cmd;
        logic dat;
    } mmc_pins_in_t;

    // Card side outputs, a dir bit of 1 makes the line an input
    typedef struct packed {
        logic clk;
        logic cmd_out;
        logic cmd_dir;
        logic dat_out;
        logic dat_dir;
    } mmc_pins_out_t;

endpackage

`default_nettype wire

// File: kfmmc_clock_gen.sv
// Card clock divider
`default_nettype none

module kfmmc_clock_gen (
    input  logic                     clock,
    input  logic                     reset,
    input  kfmmc_bus_pkg::divisor_t  mmc_clock_cycle,
    input  logic                     active,
    output logic                     mmc_clk,
    output logic                     sample_edge,
    output logic                     shift_edge
);

    kfmmc_bus_pkg::divisor_t cycle_count;
    kfmmc_bus_pkg::divisor_t half_period;
    logic                    toggle;

    assign half_period = {1'b0, mmc_clock_cycle[7:1]};
    assign toggle      = active & (cycle_count == half_period);

    // Divider restarts at 1 whenever the clock is idle
    always_ff @(posedge clock) begin
        if (reset || !active || toggle) begin
            cycle_count <= 8'd1;
        end else begin
            cycle_count <= cycle_count + 8'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || !active) begin
            mmc_clk <= 1'b0;
        end else if (toggle) begin
            mmc_clk <= ~mmc_clk;
        end
    end

    // Rise samples, fall shifts
    assign sample_edge = toggle & ~mmc_clk;
    assign shift_edge  = toggle & mmc_clk;

endmodule

`default_nettype wire

// File: kfmmc_host_pkg.sv
// Host request and status definitions
`default_nettype none

package kfmmc_host_pkg;

    // One host request, valid while start is high
    typedef struct packed {
        logic start;
        logic cmd_receive;
        logic dat_receive;
        logic check_cmd_start;
        logic check_dat_start;
        logic load_cmd;
        logic load_dat;
        logic clear_cmd_irq;
        logic clear_dat_irq;
        logic clear_cmd_crc;
        logic clear_dat_crc;
    } request_t;

    // Per lane command from the decoder
    typedef struct packed {
        logic receive;
        logic restart;
        logic load;
        logic clear_irq;
        logic clear_crc;
    } lane_ctrl_t;

    // Sticky completion flags of one lane
    typedef struct packed {
        logic sent;
        logic received;
    } lane_irq_t;

    // Host visible status word
    typedef struct packed {
        logic      in_connecting;
        lane_irq_t command_irq;
        lane_irq_t data_irq;
        logic      timeout;
    } status_t;

endpackage

`default_nettype wire

// File: kfmmc_interface.sv
// MMC host serial engine
`default_nettype none

module kfmmc_interface #(
    parameter logic [31:0] TIMEOUT = 32'hFFFF_FFFF
) (
    input  logic                         clock,
    input  logic                         reset,
    input  kfmmc_host_pkg::request_t     request,
    input  kfmmc_bus_pkg::mmc_byte_t     send_command,
    input  kfmmc_bus_pkg::mmc_byte_t     send_data,
    input  kfmmc_bus_pkg::divisor_t      mmc_clock_cycle,
    input  kfmmc_bus_pkg::mmc_pins_in_t  pins_in,
    output kfmmc_bus_pkg::mmc_pins_out_t pins_out,
    output kfmmc_bus_pkg::mmc_byte_t     received_response,
    output kfmmc_bus_pkg::mmc_byte_t     received_data,
    output kfmmc_bus_pkg::cmd_crc_t      send_command_crc,
    output kfmmc_bus_pkg::cmd_crc_t      received_response_crc,
    output kfmmc_bus_pkg::dat_crc_t      send_data_crc,
    output kfmmc_bus_pkg::dat_crc_t      received_data_crc,
    output kfmmc_host_pkg::status_t      status
);

    kfmmc_host_pkg::lane_ctrl_t cmd_ctrl;
    kfmmc_host_pkg::lane_ctrl_t dat_ctrl;
    kfmmc_host_pkg::lane_irq_t  cmd_irq;
    kfmmc_host_pkg::lane_irq_t  dat_irq;
    logic                       mmc_clk;
    logic                       sample_edge;
    logic                       shift_edge;
    logic                       active;
    logic                       cmd_line_out;
    logic                       dat_line_out;

    kfmmc_request_decode i_request_decode (
        .clock    (clock),
        .reset    (reset),
        .request  (request),
        .cmd_ctrl (cmd_ctrl),
        .dat_ctrl (dat_ctrl)
    );

    kfmmc_clock_gen i_clock_gen (
        .clock           (clock),
        .reset           (reset),
        .mmc_clock_cycle (mmc_clock_cycle),
        .active          (active),
        .mmc_clk         (mmc_clk),
        .sample_edge     (sample_edge),
        .shift_edge      (shift_edge)
    );

    kfmmc_lane #(
        .crc_t    (kfmmc_bus_pkg::cmd_crc_t),
        .CRC_POLY (kfmmc_bus_pkg::CMD_CRC_POLY)
    ) i_command_lane (
        .clock       (clock),
        .reset       (reset),
        .ctrl        (cmd_ctrl),
        .tx_byte     (send_command),
        .sample_edge (sample_edge),
        .shift_edge  (shift_edge),
        .line_in     (pins_in.cmd),
        .line_out    (cmd_line_out),
        .rx_byte     (received_response),
        .tx_crc      (send_command_crc),
        .rx_crc      (received_response_crc),
        .irq         (cmd_irq)
    );

    kfmmc_lane #(
        .crc_t    (kfmmc_bus_pkg::dat_crc_t),
        .CRC_POLY (kfmmc_bus_pkg::DAT_CRC_POLY)
    ) i_data_lane (
        .clock       (clock),
        .reset       (reset),
        .ctrl        (dat_ctrl),
        .tx_byte     (send_data),
        .sample_edge (sample_edge),
        .shift_edge  (shift_edge),
        .line_in     (pins_in.dat),
        .line_out    (dat_line_out),
        .rx_byte     (received_data),
        .tx_crc      (send_data_crc),
        .rx_crc      (received_data_crc),
        .irq         (dat_irq)
    );

    kfmmc_status #(
        .TIMEOUT (TIMEOUT)
    ) i_status (
        .clock       (clock),
        .reset       (reset),
        .start       (request.start),
        .sample_edge (sample_edge),
        .shift_edge  (shift_edge),
        .cmd_irq     (cmd_irq),
        .dat_irq     (dat_irq),
        .status      (status),
        .active      (active)
    );

    // Direction follows the registered receive bit of each lane
    always_comb begin
        pins_out.clk     = mmc_clk;
        pins_out.cmd_out = cmd_line_out;
        pins_out.cmd_dir = cmd_ctrl.receive;
        pins_out.dat_out = dat_line_out;
        pins_out.dat_dir = dat_ctrl.receive;
    end

endmodule

`default_nettype wire

// File: kfmmc_lane.sv
// Serial lane with CRC
`default_nettype none

module kfmmc_lane #(
    parameter type  crc_t    = kfmmc_bus_pkg::cmd_crc_t,
    parameter crc_t CRC_POLY = kfmmc_bus_pkg::CMD_CRC_POLY
) (
    input  logic                       clock,
    input  logic                       reset,
    input  kfmmc_host_pkg::lane_ctrl_t ctrl,
    input  kfmmc_bus_pkg::mmc_byte_t   tx_byte,
    input  logic                       sample_edge,
    input  logic                       shift_edge,
    input  logic                       line_in,
    output logic                       line_out,
    output kfmmc_bus_pkg::mmc_byte_t   rx_byte,
    output crc_t                       tx_crc,
    output crc_t                       rx_crc,
    output kfmmc_host_pkg::lane_irq_t  irq
);

    localparam int CRC_WIDTH = $bits(crc_t);

    kfmmc_bus_pkg::mmc_byte_t tx_shift;
    kfmmc_bus_pkg::mmc_byte_t rx_shift;
    logic [3:0]               bit_count;
    logic                     started;
    logic                     byte_done;
    logic                     take_bit;

    // One serial step of the CRC
    function automatic crc_t crc_step(input crc_t crc, input logic bit_in);
        logic feedback;
        feedback = crc[CRC_WIDTH-1] ^ bit_in;
        return {crc[CRC_WIDTH-2:0], 1'b0} ^ (feedback ? CRC_POLY : crc_t'(0));
    endfunction

    assign byte_done = (bit_count == 4'd8);

    // Bits after the start bit when receiving, every bit when sending
    assign take_bit = sample_edge & ~byte_done & (started | ~ctrl.receive);

    // Start bit search
    always_ff @(posedge clock) begin
        if (reset || ctrl.restart) begin
            started <= 1'b0;
        end else if (ctrl.receive && sample_edge && !started && !line_in) begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || ctrl.restart || ctrl.load) begin
            bit_count <= 4'd0;
        end else if (ctrl.clear_irq && byte_done) begin
            bit_count <= 4'd0;
        end else if (take_bit) begin
            bit_count <= bit_count + 4'd1;
        end
    end

    // Send side, ones fill in behind the byte
    always_ff @(posedge clock) begin
        if (reset) begin
            tx_shift <= '0;
        end else if (ctrl.load) begin
            tx_shift <= tx_byte;
        end else if (shift_edge && !ctrl.receive) begin
            tx_shift <= {tx_shift[6:0], 1'b1};
        end
    end

    assign line_out = ctrl.receive | tx_shift[7];

    always_ff @(posedge clock) begin
        if (reset) begin
            rx_shift <= '0;
        end else if (take_bit && ctrl.receive) begin
            rx_shift <= {rx_shift[6:0], line_in};
        end
    end

    assign rx_byte = rx_shift;

    // Each CRC steps only in its own direction
    always_ff @(posedge clock) begin
        if (reset || ctrl.clear_crc) begin
            tx_crc <= '0;
        end else if (take_bit && !ctrl.receive) begin
            tx_crc <= crc_step(tx_crc, tx_shift[7]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || ctrl.clear_crc) begin
            rx_crc <= '0;
        end else if (take_bit && ctrl.receive) begin
            rx_crc <= crc_step(rx_crc, line_in);
        end
    end

    // Sticky completion flags
    always_ff @(posedge clock) begin
        if (reset || ctrl.receive || ctrl.clear_irq) begin
            irq.sent <= 1'b0;
        end else if (shift_edge && byte_done) begin
            irq.sent <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || !ctrl.receive || ctrl.clear_irq) begin
            irq.received <= 1'b0;
        end else if (shift_edge && byte_done) begin
            irq.received <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: kfmmc_properties.sv
// MMC host engine assertions
`default_nettype none

module kfmmc_properties (
    input logic                         clock,
    input logic                         reset,
    input kfmmc_host_pkg::request_t     request,
    input kfmmc_host_pkg::status_t      status,
    input kfmmc_bus_pkg::mmc_pins_out_t pins_out
);
    timeunit 1ns;
    timeprecision 1ps;

    int         failure_count = 0;
    logic [3:0] lane_irqs;

    assign lane_irqs = {status.command_irq, status.data_irq};

    // Card clock parked while an interrupt is pending
    clock_parked: assert property (@(posedge clock) disable iff (reset)
        !status.in_connecting |-> !pins_out.clk)
        else begin
            failure_count++;
            $error("mmc_clk high while an interrupt is pending");
        end

    cmd_idle_high: assert property (@(posedge clock) disable iff (reset)
        pins_out.cmd_dir |-> pins_out.cmd_out)
        else begin
            failure_count++;
            $error("cmd_out low while the command line is an input");
        end

    dat_idle_high: assert property (@(posedge clock) disable iff (reset)
        pins_out.dat_dir |-> pins_out.dat_out)
        else begin
            failure_count++;
            $error("dat_out low while the data line is an input");
        end

    // Stopped engine raises nothing new until the next request
    no_irq_when_stopped: assert property (@(posedge clock) disable iff (reset)
        (!status.in_connecting && !request.start) |=> ((lane_irqs & ~$past(lane_irqs)) == 4'b0))
        else begin
            failure_count++;
            $error("lane interrupt rose while the engine was stopped");
        end

endmodule

bind kfmmc_interface kfmmc_properties i_properties (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .status   (status),
    .pins_out (pins_out)
);

`default_nettype wire

// File: kfmmc_request_decode.sv
// Host request decoder
`default_nettype none

module kfmmc_request_decode (
    input  logic                       clock,
    input  logic                       reset,
    input  kfmmc_host_pkg::request_t   request,
    output kfmmc_host_pkg::lane_ctrl_t cmd_ctrl,
    output kfmmc_host_pkg::lane_ctrl_t dat_ctrl
);

    // 1 means the lane receives, the line is an input
    logic cmd_dir;
    logic dat_dir;

    function automatic kfmmc_host_pkg::lane_ctrl_t lane_decode(
        input logic start,
        input logic dir,
        input logic receive,
        input logic check_start,
        input logic load,
        input logic clear_irq,
        input logic clear_crc
    );
        kfmmc_host_pkg::lane_ctrl_t ctrl;
        ctrl.receive   = dir;
        // New direction, or a fresh start bit search while receiving
        ctrl.restart   = start & ((dir != receive) | (receive & check_start));
        ctrl.load      = start & load & ~receive;
        ctrl.clear_irq = start & clear_irq;
        ctrl.clear_crc = clear_crc;
        return ctrl;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            cmd_dir <= 1'b1;
            dat_dir <= 1'b1;
        end else if (request.start) begin
            cmd_dir <= request.cmd_receive;
            dat_dir <= request.dat_receive;
        end
    end

    always_comb begin
        cmd_ctrl = lane_decode(request.start, cmd_dir, request.cmd_receive,
                               request.check_cmd_start, request.load_cmd,
                               request.clear_cmd_irq, request.clear_cmd_crc);
        dat_ctrl = lane_decode(request.start, dat_dir, request.dat_receive,
                               request.check_dat_start, request.load_dat,
                               request.clear_dat_irq, request.clear_dat_crc);
    end

endmodule

`default_nettype wire

// File: kfmmc_status.sv
// Timeout and interrupt status
`default_nettype none

module kfmmc_status #(
    parameter logic [31:0] TIMEOUT = 32'hFFFF_FFFF
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      sample_edge,
    input  logic                      shift_edge,
    input  kfmmc_host_pkg::lane_irq_t cmd_irq,
    input  kfmmc_host_pkg::lane_irq_t dat_irq,
    output kfmmc_host_pkg::status_t   status,
    output logic                      active
);

    logic [31:0] timeout_count;
    logic        timeout_irq;
    logic        timed_out;
    logic        any_irq;

    assign timed_out = (timeout_count == 32'd0);

    // Counts card clock periods, stops at zero
    always_ff @(posedge clock) begin
        if (reset || start) begin
            timeout_count <= TIMEOUT;
        end else if (sample_edge && !timed_out) begin
            timeout_count <= timeout_count - 32'd1;
        end
    end

    // Set out of reset so the card clock stays off until the first request
    always_ff @(posedge clock) begin
        if (reset) begin
            timeout_irq <= 1'b1;
        end else if (start) begin
            timeout_irq <= 1'b0;
        end else if (shift_edge && timed_out) begin
            timeout_irq <= 1'b1;
        end
    end

    assign any_irq = cmd_irq.sent | cmd_irq.received
                   | dat_irq.sent | dat_irq.received
                   | timeout_irq;

    assign active = ~any_irq;

    always_comb begin
        status.in_connecting = active;
        status.command_irq   = cmd_irq;
        status.data_irq      = dat_irq;
        status.timeout       = timeout_irq;
    end

endmodule

`default_nettype wire

// File: tb_kfmmc_interface.sv
// MMC host engine testbench
`default_nettype none

module tb_kfmmc_interface;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 24;
    localparam int DIVISOR = 4;
    localparam int CLOCK_PERIOD = 100;
    localparam int NUM_TESTS = 5;
    // One transfer never needs more than this many system cycles
    localparam int WAIT_CYCLES = (2 * TIMEOUT + 20) * DIVISOR;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * WAIT_CYCLES + 100;

    logic                         clock = 1'b0;
    logic                         reset;
    kfmmc_host_pkg::request_t     request;
    kfmmc_bus_pkg::mmc_byte_t     send_command;
    kfmmc_bus_pkg::mmc_byte_t     send_data;
    kfmmc_bus_pkg::divisor_t      mmc_clock_cycle;
    kfmmc_bus_pkg::mmc_pins_in_t  pins_in;
    kfmmc_bus_pkg::mmc_pins_out_t pins_out;
    kfmmc_bus_pkg::mmc_byte_t     received_response;
    kfmmc_bus_pkg::mmc_byte_t     received_data;
    kfmmc_bus_pkg::cmd_crc_t      send_command_crc;
    kfmmc_bus_pkg::cmd_crc_t      received_response_crc;
    kfmmc_bus_pkg::dat_crc_t      send_data_crc;
    kfmmc_bus_pkg::dat_crc_t      received_data_crc;
    kfmmc_host_pkg::status_t      status;
    logic                         mmc_clk;
    logic                         card_cmd_bits[$];
    logic                         card_dat_bits[$];
    logic                         seen_cmd[$];
    logic                         seen_dat[$];
    int                           error_count = 0;
    int                           seed = 10617;

    kfmmc_interface #(
        .TIMEOUT (TIMEOUT)
    ) i_dut (
        .clock                 (clock),
        .reset                 (reset),
        .request               (request),
        .send_command          (send_command),
        .send_data             (send_data),
        .mmc_clock_cycle       (mmc_clock_cycle),
        .pins_in               (pins_in),
        .pins_out              (pins_out),
        .received_response     (received_response),
        .received_data         (received_data),
        .send_command_crc      (send_command_crc),
        .received_response_crc (received_response_crc),
        .send_data_crc         (send_data_crc),
        .received_data_crc     (received_data_crc),
        .status                (status)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    assign mmc_clk = pins_out.clk;

    // Card drives its lines on card clock falls, idles high
    initial begin
        pins_in = 2'b11;
        forever begin
            @(negedge mmc_clk);
            if (card_cmd_bits.size() > 0) begin
                pins_in.cmd <= card_cmd_bits.pop_front();
            end else begin
                pins_in.cmd <= 1'b1;
            end
            if (card_dat_bits.size() > 0) begin
                pins_in.dat <= card_dat_bits.pop_front();
            end else begin
                pins_in.dat <= 1'b1;
            end
        end
    end

    always @(posedge mmc_clk) begin
        seen_cmd.push_back(pins_out.cmd_out);
        seen_dat.push_back(pins_out.dat_out);
    end

    // Serial CRC from zero, most significant bit first
    function automatic logic [15:0] reference_crc(input logic [15:0] poly, input int width,
                                                  input logic [7:0] data);
        logic [15:0] crc;
        logic [16:0] mask;
        logic        feedback;
        crc = '0;
        mask = (17'h1 << width) - 17'h1;
        for (int i = 7; i >= 0; i--) begin
            feedback = crc[width - 1] ^ data[i];
            crc = (crc << 1) & mask[15:0];
            if (feedback) begin
                crc = crc ^ poly;
            end
        end
        return crc;
    endfunction

    function automatic kfmmc_host_pkg::status_t make_status(input logic connecting,
            input logic [1:0] cmd_irq, input logic [1:0] dat_irq, input logic timeout);
        kfmmc_host_pkg::status_t value;
        value.in_connecting = connecting;
        value.command_irq   = cmd_irq;
        value.data_irq      = dat_irq;
        value.timeout       = timeout;
        return value;
    endfunction

    // Both lanes listening for a start bit, all interrupts cleared
    function automatic kfmmc_host_pkg::request_t listen_request();
        kfmmc_host_pkg::request_t req;
        req = '0;
        req.start           = 1'b1;
        req.cmd_receive     = 1'b1;
        req.dat_receive     = 1'b1;
        req.check_cmd_start = 1'b1;
        req.check_dat_start = 1'b1;
        req.clear_cmd_irq   = 1'b1;
        req.clear_dat_irq   = 1'b1;
        return req;
    endfunction

    task automatic check_byte(input string name, input kfmmc_bus_pkg::mmc_byte_t expected,
                              input kfmmc_bus_pkg::mmc_byte_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_cmd_crc(input string name, input kfmmc_bus_pkg::cmd_crc_t expected,
                                 input kfmmc_bus_pkg::cmd_crc_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_dat_crc(input string name, input kfmmc_bus_pkg::dat_crc_t expected,
                                 input kfmmc_bus_pkg::dat_crc_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_status(input string name, input kfmmc_host_pkg::status_t expected,
                                input kfmmc_host_pkg::status_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_pins(input string name, input kfmmc_bus_pkg::mmc_pins_out_t expected,
                              input kfmmc_bus_pkg::mmc_pins_out_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_line_bits(input string name, input logic bits[$],
                                   input kfmmc_bus_pkg::mmc_byte_t expected);
        kfmmc_bus_pkg::mmc_byte_t assembled;
        if (bits.size() != 8) begin
            error_count++;
            $display("%s showed %0d bits on card clock rises instead of 8", name, bits.size());
        end else begin
            for (int i = 0; i < 8; i++) begin
                assembled[7 - i] = bits[i];
            end
            check_byte(name, expected, assembled);
        end
    endtask

    task automatic queue_card_byte(ref logic bits[$], input kfmmc_bus_pkg::mmc_byte_t value);
        bits.push_back(1'b0);
        for (int i = 7; i >= 0; i--) begin
            bits.push_back(value[i]);
        end
    endtask

    // Start is high for exactly one rising edge
    task automatic issue(input kfmmc_host_pkg::request_t req);
        @(negedge clock);
        request = req;
        @(negedge clock);
        request = '0;
    endtask

    task automatic wait_for_interrupt(input string what);
        int cycles;
        cycles = 0;
        while (status.in_connecting && cycles < WAIT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (status.in_connecting) begin
            error_count++;
            $display("%s did not raise an interrupt within %0d cycles", what, WAIT_CYCLES);
        end
    endtask

    task automatic test_reset_state();
        check_status("status", make_status(1'b0, 2'b00, 2'b00, 1'b1), status);
        check_pins("pins_out", kfmmc_bus_pkg::mmc_pins_out_t'(5'b01111), pins_out);
        check_byte("received_response", 8'h00, received_response);
        check_byte("received_data", 8'h00, received_data);
        check_cmd_crc("send_command_crc", 7'h00, send_command_crc);
        check_cmd_crc("received_response_crc", 7'h00, received_response_crc);
        check_dat_crc("send_data_crc", 16'h0000, send_data_crc);
        check_dat_crc("received_data_crc", 16'h0000, received_data_crc);
    endtask

    task automatic test_command_send();
        kfmmc_host_pkg::request_t req;
        kfmmc_bus_pkg::mmc_byte_t value;
        value = kfmmc_bus_pkg::mmc_byte_t'($random(seed));
        req = listen_request();
        req.cmd_receive = 1'b0;
        req.load_cmd    = 1'b1;
        send_command = value;
        seen_cmd.delete();
        issue(req);
        wait_for_interrupt("command send");
        check_line_bits("cmd_out", seen_cmd, value);
        check_cmd_crc("send_command_crc", kfmmc_bus_pkg::cmd_crc_t'(
            reference_crc(16'(kfmmc_bus_pkg::CMD_CRC_POLY), 7, value)), send_command_crc);
        check_status("status", make_status(1'b0, 2'b10, 2'b00, 1'b0), status);
    endtask

    task automatic test_command_receive();
        kfmmc_bus_pkg::mmc_byte_t value;
        value = kfmmc_bus_pkg::mmc_byte_t'($random(seed));
        queue_card_byte(card_cmd_bits, value);
        issue(listen_request());
        wait_for_interrupt("command receive");
        check_byte("received_response", value, received_response);
        check_cmd_crc("received_response_crc", kfmmc_bus_pkg::cmd_crc_t'(
            reference_crc(16'(kfmmc_bus_pkg::CMD_CRC_POLY), 7, value)), received_response_crc);
        check_status("status", make_status(1'b0, 2'b01, 2'b00, 1'b0), status);
    endtask

    task automatic test_data_lane();
        kfmmc_host_pkg::request_t req;
        kfmmc_bus_pkg::mmc_byte_t sent;
        kfmmc_bus_pkg::mmc_byte_t got;
        sent = kfmmc_bus_pkg::mmc_byte_t'($random(seed));
        got = kfmmc_bus_pkg::mmc_byte_t'($random(seed));
        req = listen_request();
        req.dat_receive = 1'b0;
        req.load_dat    = 1'b1;
        send_data = sent;
        seen_dat.delete();
        issue(req);
        wait_for_interrupt("data send");
        check_line_bits("dat_out", seen_dat, sent);
        check_dat_crc("send_data_crc",
            reference_crc(kfmmc_bus_pkg::DAT_CRC_POLY, 16, sent), send_data_crc);
        check_status("status", make_status(1'b0, 2'b00, 2'b10, 1'b0), status);
        queue_card_byte(card_dat_bits, got);
        issue(listen_request());
        wait_for_interrupt("data receive");
        check_byte("received_data", got, received_data);
        check_dat_crc("received_data_crc",
            reference_crc(kfmmc_bus_pkg::DAT_CRC_POLY, 16, got), received_data_crc);
        check_status("status", make_status(1'b0, 2'b00, 2'b01, 1'b0), status);
        // CRC clear works without start
        req = '0;
        req.clear_dat_crc = 1'b1;
        issue(req);
        check_dat_crc("send_data_crc", 16'h0000, send_data_crc);
        check_dat_crc("received_data_crc", 16'h0000, received_data_crc);
    endtask

    task automatic test_timeout();
        issue(listen_request());
        wait_for_interrupt("timeout");
        check_status("status", make_status(1'b0, 2'b00, 2'b00, 1'b1), status);
        issue(listen_request());
        check_status("status", make_status(1'b1, 2'b00, 2'b00, 1'b0), status);
    endtask

    initial begin
        reset = 1'b1;
        request = '0;
        send_command = '0;
        send_data = '0;
        mmc_clock_cycle = kfmmc_bus_pkg::divisor_t'(DIVISOR);
        repeat (2) @(negedge clock);
        reset = 1'b0;
        test_reset_state();
        test_command_send();
        test_command_receive();
        test_data_lane();
        test_timeout();
        $display("Errors: %0d from checks, %0d from assertions",
                 error_count, i_dut.i_properties.failure_count);
        if (error_count == 0 && i_dut.i_properties.failure_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests completed",
                 WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
